// File: hdl/dr_consts.svh
/*
 * sizes of the PUSCH dimension-reduction core,
 * shared by the package, the RTL and the testbench
 */
`ifndef DR_CONSTS_SVH
`define DR_CONSTS_SVH

// array sizes
`define DR_ANT        8     // receive antennas
`define DR_BEAM       8     // Hadamard beams
`define DR_SEL        2     // beams kept per RBG

// datapath widths
`define DR_IQ_W       16    // antenna I or Q
`define DR_BEAM_W     19    // 8-way sum needs 3 more bits
`define DR_ACC_W      44    // 38-bit RE power over up to 48 REs
`define DR_RE_W       6     // RE position in an RBG
`define DR_RBG_W      4     // RBG number in a symbol

`define DR_OUT_SHIFT  3     // output scale, divide by 8

`endif

// File: hdl/dr_pkg.sv
/*
 * shared types of the dimension-reduction core, import with dr_pkg::*
 */
`default_nettype none

`include "dr_consts.svh"

package dr_pkg;

    typedef logic signed [`DR_IQ_W-1:0]   iq_t;       // antenna sample
    typedef logic signed [`DR_BEAM_W-1:0] beam_t;     // formed beam sample
    typedef logic        [2:0]            beam_idx_t;
    typedef logic        [`DR_ACC_W-1:0]  acc_t;      // beam power sum
    typedef logic        [`DR_RE_W-1:0]   re_cnt_t;
    typedef logic        [`DR_RBG_W-1:0]  rbg_idx_t;

    // RBG size select, reserved code behaves as 16 PRB
    typedef enum logic [1:0] {
        RBG_4PRB  = 2'd0,   // 12 REs
        RBG_8PRB  = 2'd1,   // 24 REs
        RBG_16PRB = 2'd2,   // 48 REs
        RBG_RSVD  = 2'd3
    } rbg_size_e;

endpackage

`default_nettype wire

// File: hdl/beam_stream_if.sv
/*
 * stream of formed beams with RBG markers, one RE per valid cycle;
 * beam_former is the source, beam_rank and beam_pick listen
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

interface beam_stream_if import dr_pkg::*; ();

    logic     vld;
    logic     sop;                  // first RE of a symbol
    logic     rbg_first;
    logic     rbg_last;
    rbg_idx_t rbg_idx;
    beam_t    beam_i [`DR_BEAM];
    beam_t    beam_q [`DR_BEAM];

    modport src (
        output vld, sop, rbg_first, rbg_last, rbg_idx, beam_i, beam_q
    );

    modport dst (
        input  vld, sop, rbg_first, rbg_last, rbg_idx, beam_i, beam_q
    );

endinterface

`default_nettype wire

// File: hdl/rbg_tracker.sv
/*
 * RE counter per RBG and RBG counter per symbol; markers are combinational
 * on the incoming RE, counters step at the edge that ends it
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

module rbg_tracker import dr_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire logic      i_vld,
    input  wire logic      i_sop,
    input  wire rbg_size_e i_rbg_size,
    output logic           o_rbg_first,
    output logic           o_rbg_last,
    output rbg_idx_t       o_rbg_idx
);

    re_cnt_t  re_cnt;       // position of the next RE
    rbg_idx_t rbg_cnt;
    re_cnt_t  rbg_len;
    re_cnt_t  re_pos;       // position of the current RE
    rbg_idx_t rbg_cur;

    always_comb begin
        case (i_rbg_size)
            RBG_4PRB:  rbg_len = re_cnt_t'(12);
            RBG_8PRB:  rbg_len = re_cnt_t'(24);
            default:   rbg_len = re_cnt_t'(48);   // 16 PRB and reserved
        endcase
    end

    // sop restarts on the RE that carries it
    assign re_pos  = i_sop ? '0 : re_cnt;
    assign rbg_cur = i_sop ? '0 : rbg_cnt;

    assign o_rbg_first = i_vld && (re_pos == '0);
    assign o_rbg_last  = i_vld && (re_pos == re_cnt_t'(rbg_len - 1'b1));
    assign o_rbg_idx   = rbg_cur;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt  <= '0;
            rbg_cnt <= '0;
        end else if (i_vld) begin
            if (o_rbg_last) begin
                re_cnt  <= '0;
                rbg_cnt <= rbg_cur + 1'b1;  // wraps with the index width
            end else begin
                re_cnt  <= re_pos + 1'b1;
                rbg_cnt <= rbg_cur;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/beam_former.sv
/*
 * forms 8 Walsh-Hadamard beams from 8 antennas, one register stage;
 * drives the beam stream together with the RBG markers
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

module beam_former import dr_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_reset,
    input  wire logic     i_vld,
    input  wire logic     i_sop,
    input  wire logic     i_rbg_first,
    input  wire logic     i_rbg_last,
    input  wire rbg_idx_t i_rbg_idx,
    input  wire iq_t      i_ant_i [`DR_ANT],
    input  wire iq_t      i_ant_q [`DR_ANT],
    beam_stream_if.src    o_bs
);

    beam_t sum_i [`DR_BEAM];
    beam_t sum_q [`DR_BEAM];

    //----------------------------------------
    // sign of antenna a in beam b is the parity of a & b
    //----------------------------------------
    always_comb begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            sum_i[b] = '0;
            sum_q[b] = '0;
            for (int a = 0; a < `DR_ANT; a++) begin
                if (^(a[2:0] & b[2:0])) begin   // odd count, weight -1
                    sum_i[b] = sum_i[b] - beam_t'(i_ant_i[a]);
                    sum_q[b] = sum_q[b] - beam_t'(i_ant_q[a]);
                end else begin
                    sum_i[b] = sum_i[b] + beam_t'(i_ant_i[a]);
                    sum_q[b] = sum_q[b] + beam_t'(i_ant_q[a]);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bs.vld       <= 1'b0;
            o_bs.sop       <= 1'b0;
            o_bs.rbg_first <= 1'b0;
            o_bs.rbg_last  <= 1'b0;
        end else begin
            o_bs.vld       <= i_vld;
            o_bs.sop       <= i_vld && i_sop;
            o_bs.rbg_first <= i_rbg_first;    // already qualified by vld
            o_bs.rbg_last  <= i_rbg_last;
        end
    end

    always_ff @(posedge i_clk) begin
        o_bs.rbg_idx <= i_rbg_idx;
        o_bs.beam_i  <= sum_i;
        o_bs.beam_q  <= sum_q;
    end

endmodule

`default_nettype wire

// File: hdl/beam_rank.sv
/*
 * per-RBG beam power sums and top-2 ranking; the new selection is
 * registered at the end of the stream cycle of the last RE
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

module beam_rank import dr_pkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_reset,
    beam_stream_if.dst i_bs,
    output beam_idx_t  o_sel0,
    output beam_idx_t  o_sel1
);

    acc_t                       acc     [`DR_BEAM];
    acc_t                       sum_now [`DR_BEAM];  // sums including this RE
    logic signed [`DR_ACC_W-1:0] ext_i  [`DR_BEAM];
    logic signed [`DR_ACC_W-1:0] ext_q  [`DR_BEAM];
    beam_idx_t                  best0;
    beam_idx_t                  best1;
    acc_t                       pwr0;
    acc_t                       pwr1;

    //----------------------------------------
    // RE power and running sums
    //----------------------------------------
    always_comb begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            ext_i[b]   = acc_t'(i_bs.beam_i[b]);    // sign extend before squaring
            ext_q[b]   = acc_t'(i_bs.beam_q[b]);
            sum_now[b] = (i_bs.sop ? '0 : acc[b])
                       + acc_t'(ext_i[b] * ext_i[b] + ext_q[b] * ext_q[b]);
        end
    end

    //----------------------------------------
    // strict compare, so a tie keeps the lower index
    //----------------------------------------
    always_comb begin
        best0 = '0;
        pwr0  = sum_now[0];
        for (int b = 1; b < `DR_BEAM; b++) begin
            if (sum_now[b] > pwr0) begin
                best0 = beam_idx_t'(b);
                pwr0  = sum_now[b];
            end
        end
        best1 = (best0 == '0) ? beam_idx_t'(1) : beam_idx_t'(0);
        pwr1  = sum_now[best1];
        for (int b = 0; b < `DR_BEAM; b++) begin
            if (beam_idx_t'(b) != best0 && sum_now[b] > pwr1) begin
                best1 = beam_idx_t'(b);
                pwr1  = sum_now[b];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_sel0 <= beam_idx_t'(0);
            o_sel1 <= beam_idx_t'(1);
            for (int b = 0; b < `DR_BEAM; b++) acc[b] <= '0;
        end else if (i_bs.vld) begin
            if (i_bs.rbg_last) begin
                o_sel0 <= best0;
                o_sel1 <= best1;
                for (int b = 0; b < `DR_BEAM; b++) acc[b] <= '0;  // next RBG
            end else begin
                acc <= sum_now;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/beam_pick.sv
/*
 * takes the two selected beams off the stream, scales them by 1/8
 * and registers them with the markers for output
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

module beam_pick import dr_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    beam_stream_if.dst     i_bs,
    input  wire beam_idx_t i_sel0,
    input  wire beam_idx_t i_sel1,
    output logic           o_dr_vld,
    output logic           o_dr_sop,
    output logic           o_rbg_load,
    output rbg_idx_t       o_rbg_idx,
    output beam_t          o_dr_i     [`DR_SEL],
    output beam_t          o_dr_q     [`DR_SEL],
    output beam_idx_t      o_beam_idx [`DR_SEL]
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_dr_vld   <= 1'b0;
            o_dr_sop   <= 1'b0;
            o_rbg_load <= 1'b0;
        end else begin
            o_dr_vld   <= i_bs.vld;
            o_dr_sop   <= i_bs.sop;
            o_rbg_load <= i_bs.rbg_first;   // selection changes here
        end
    end

    // payload holds between REs
    always_ff @(posedge i_clk) begin
        if (i_bs.vld) begin
            o_rbg_idx     <= i_bs.rbg_idx;
            o_dr_i[0]     <= i_bs.beam_i[i_sel0] >>> `DR_OUT_SHIFT;
            o_dr_q[0]     <= i_bs.beam_q[i_sel0] >>> `DR_OUT_SHIFT;
            o_dr_i[1]     <= i_bs.beam_i[i_sel1] >>> `DR_OUT_SHIFT;
            o_dr_q[1]     <= i_bs.beam_q[i_sel1] >>> `DR_OUT_SHIFT;
            o_beam_idx[0] <= i_sel0;
            o_beam_idx[1] <= i_sel1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dr_core.sv
/*
 * top level of the PUSCH dimension-reduction core; one RE in per valid
 * cycle, the two strongest beams of the previous RBG out 2 cycles later
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

module dr_core import dr_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire rbg_size_e i_rbg_size,     // static during a run
    input  wire iq_t       i_ant_i [`DR_ANT],
    input  wire iq_t       i_ant_q [`DR_ANT],
    input  wire logic      i_vld,
    input  wire logic      i_sop,
    output logic           o_dr_vld,
    output logic           o_dr_sop,
    output logic           o_rbg_load,
    output rbg_idx_t       o_rbg_idx,
    output beam_t          o_dr_i     [`DR_SEL],
    output beam_t          o_dr_q     [`DR_SEL],
    output beam_idx_t      o_beam_idx [`DR_SEL]
);

    logic      rbg_first;
    logic      rbg_last;
    rbg_idx_t  rbg_idx;
    beam_idx_t sel0;
    beam_idx_t sel1;

    beam_stream_if bs_if ();

    //----------------------------------------
    // segmentation and beamforming
    //----------------------------------------
    rbg_tracker rbg_tracker_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_vld       (i_vld),
        .i_sop       (i_sop),
        .i_rbg_size  (i_rbg_size),
        .o_rbg_first (rbg_first),
        .o_rbg_last  (rbg_last),
        .o_rbg_idx   (rbg_idx)
    );

    beam_former beam_former_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_vld       (i_vld),
        .i_sop       (i_sop),
        .i_rbg_first (rbg_first),
        .i_rbg_last  (rbg_last),
        .i_rbg_idx   (rbg_idx),
        .i_ant_i     (i_ant_i),
        .i_ant_q     (i_ant_q),
        .o_bs        (bs_if.src)
    );

    //----------------------------------------
    // ranking and output selection
    //----------------------------------------
    beam_rank beam_rank_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_bs    (bs_if.dst),
        .o_sel0  (sel0),
        .o_sel1  (sel1)
    );

    beam_pick beam_pick_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_bs       (bs_if.dst),
        .i_sel0     (sel0),
        .i_sel1     (sel1),
        .o_dr_vld   (o_dr_vld),
        .o_dr_sop   (o_dr_sop),
        .o_rbg_load (o_rbg_load),
        .o_rbg_idx  (o_rbg_idx),
        .o_dr_i     (o_dr_i),
        .o_dr_q     (o_dr_q),
        .o_beam_idx (o_beam_idx)
    );

endmodule

`default_nettype wire

// File: tb/dr_core_chk.sv
/*
 * concurrent checks on the dr_core outputs, bound into the DUT by the testbench
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

module dr_core_chk import dr_pkg::*; (
    input wire logic      i_clk,
    input wire logic      i_reset,
    input wire logic      i_vld,
    input wire logic      i_dr_vld,
    input wire logic      i_dr_sop,
    input wire logic      i_rbg_load,
    input wire rbg_idx_t  i_rbg_idx,
    input wire beam_idx_t i_beam_idx [`DR_SEL]
);

    load_has_vld: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rbg_load |-> i_dr_vld)
        else $error("o_rbg_load high without o_dr_vld");

    // a symbol always opens RBG 0
    sop_opens_rbg: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dr_sop |-> (i_rbg_load && i_rbg_idx == '0))
        else $error("o_dr_sop without o_rbg_load or with nonzero o_rbg_idx");

    vld_latency: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dr_vld == $past(i_vld, 2))      // two register stages
        else $error("o_dr_vld does not follow i_vld by 2 cycles");

    beams_differ: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dr_vld |-> i_beam_idx[0] != i_beam_idx[1])
        else $error("both output beams carry the same index");

endmodule

`default_nettype wire

// File: tb/dr_core_tb.sv
/*
 * testbench for dr_core: directed tests against a queue-based reference model,
 * every output RE compared on the falling clock edge
 */
`timescale 1ns/1ps
`default_nettype none

`include "dr_consts.svh"

module dr_core_tb import dr_pkg::*; ();

    localparam int TOTAL_RE = 1 + 16 + 606 + 28 + 600;  // REs over all tests

    typedef struct packed {
        bit sop;
        bit load;
        int idx;
        int i0, q0, i1, q1;     // scaled beams
        int b0, b1;
    } exp_t;

    logic      i_clk;
    logic      i_reset;
    rbg_size_e i_rbg_size;
    iq_t       i_ant_i [`DR_ANT];
    iq_t       i_ant_q [`DR_ANT];
    logic      i_vld;
    logic      i_sop;
    logic      o_dr_vld;
    logic      o_dr_sop;
    logic      o_rbg_load;
    rbg_idx_t  o_rbg_idx;
    beam_t     o_dr_i     [`DR_SEL];
    beam_t     o_dr_q     [`DR_SEL];
    beam_idx_t o_beam_idx [`DR_SEL];

    exp_t   exp_q [$];          // expected output REs, oldest first
    int     stim_i [`DR_ANT];
    int     stim_q [`DR_ANT];
    int     m_re_cnt;
    int     m_rbg_cnt;
    int     m_sel0;
    int     m_sel1;
    int     rbg_len;
    longint m_acc [`DR_BEAM];
    int     seed;

    dr_core dr_core_i (.*);

    bind dr_core dr_core_chk dr_core_chk_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_vld      (i_vld),
        .i_dr_vld   (o_dr_vld),
        .i_dr_sop   (o_dr_sop),
        .i_rbg_load (o_rbg_load),
        .i_rbg_idx  (o_rbg_idx),
        .i_beam_idx (o_beam_idx)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    //----------------------------------------
    // error handling and checks
    //----------------------------------------
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    //----------------------------------------
    // reference model
    //----------------------------------------
    function automatic int hadamard_sign(input int a, input int b);
        return ($countones(a & b) % 2 == 0) ? 1 : -1;   // parity of a & b
    endfunction

    function automatic int rbg_length(input rbg_size_e size);
        case (size)
            RBG_4PRB: return 12;
            RBG_8PRB: return 24;
            default:  return 48;
        endcase
    endfunction

    task automatic model_re(input bit sop);
        int     pos;
        int     idx;
        int     rank;
        int     bi  [`DR_BEAM];
        int     bq  [`DR_BEAM];
        longint sum [`DR_BEAM];
        exp_t   e;
        pos = sop ? 0 : m_re_cnt;
        idx = sop ? 0 : m_rbg_cnt;
        for (int b = 0; b < `DR_BEAM; b++) begin
            bi[b] = 0;
            bq[b] = 0;
            for (int a = 0; a < `DR_ANT; a++) begin
                bi[b] += hadamard_sign(a, b) * stim_i[a];
                bq[b] += hadamard_sign(a, b) * stim_q[a];
            end
            sum[b] = sop ? 64'sd0 : m_acc[b];   // sop drops the partial sums
            sum[b] += longint'(bi[b]) * longint'(bi[b]) + longint'(bq[b]) * longint'(bq[b]);
        end
        e.sop  = sop;
        e.load = (pos == 0);
        e.idx  = idx;
        e.i0   = bi[m_sel0] >>> `DR_OUT_SHIFT;
        e.q0   = bq[m_sel0] >>> `DR_OUT_SHIFT;
        e.i1   = bi[m_sel1] >>> `DR_OUT_SHIFT;
        e.q1   = bq[m_sel1] >>> `DR_OUT_SHIFT;
        e.b0   = m_sel0;
        e.b1   = m_sel1;
        exp_q.push_back(e);
        if (pos == rbg_len - 1) begin
            // ranks 0 and 1 survive, a tie goes to the lower index
            for (int b = 0; b < `DR_BEAM; b++) begin
                rank = 0;
                for (int c = 0; c < `DR_BEAM; c++) begin
                    if (sum[c] > sum[b] || (sum[c] == sum[b] && c < b))
                        rank++;
                end
                if (rank == 0)
                    m_sel0 = b;
                if (rank == 1)
                    m_sel1 = b;
            end
            m_re_cnt  = 0;
            m_rbg_cnt = (idx + 1) % (1 << `DR_RBG_W);
            for (int b = 0; b < `DR_BEAM; b++)
                m_acc[b] = 0;
        end else begin
            m_re_cnt  = pos + 1;
            m_rbg_cnt = idx;
            m_acc     = sum;
        end
    endtask

    // outputs are stable away from the rising edge
    always @(negedge i_clk) begin
        exp_t e;
        if (o_dr_vld) begin
            assert (exp_q.size() != 0) else begin
                $display("output RE at %0t ns with no input RE behind it", $time);
                stop_run();
            end
            e = exp_q.pop_front();
            check_val("o_dr_sop", int'(o_dr_sop), int'(e.sop));
            check_val("o_rbg_load", int'(o_rbg_load), int'(e.load));
            check_val("o_rbg_idx", int'(o_rbg_idx), e.idx);
            check_val("o_beam_idx[0]", int'(o_beam_idx[0]), e.b0);
            check_val("o_beam_idx[1]", int'(o_beam_idx[1]), e.b1);
            check_val("o_dr_i[0]", int'(o_dr_i[0]), e.i0);
            check_val("o_dr_q[0]", int'(o_dr_q[0]), e.q0);
            check_val("o_dr_i[1]", int'(o_dr_i[1]), e.i1);
            check_val("o_dr_q[1]", int'(o_dr_q[1]), e.q1);
        end
    end

    //----------------------------------------
    // drivers
    //----------------------------------------
    task automatic check_idle_outputs();
        check_val("o_dr_vld", int'(o_dr_vld), 0);
        check_val("o_dr_sop", int'(o_dr_sop), 0);
        check_val("o_rbg_load", int'(o_rbg_load), 0);
    endtask

    task automatic apply_reset(input rbg_size_e size);
        @(negedge i_clk);
        i_reset    = 1'b1;
        i_vld      = 1'b0;
        i_sop      = 1'b0;
        i_rbg_size = size;
        repeat (3) begin
            @(negedge i_clk);
            check_idle_outputs();
        end
        i_reset  = 1'b0;
        rbg_len  = rbg_length(size);
        m_re_cnt  = 0;
        m_rbg_cnt = 0;
        m_sel0    = 0;
        m_sel1    = 1;
        for (int b = 0; b < `DR_BEAM; b++)
            m_acc[b] = 0;
    endtask

    task automatic drive_re(input bit sop);
        @(negedge i_clk);
        i_vld = 1'b1;
        i_sop = sop;
        for (int a = 0; a < `DR_ANT; a++) begin
            i_ant_i[a] = iq_t'(stim_i[a]);
            i_ant_q[a] = iq_t'(stim_q[a]);
        end
        model_re(sop);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_vld = 1'b0;
            i_sop = 1'b0;
        end
    endtask

    // waits for every expected RE, bounded
    task automatic wait_drain();
        int n;
        n = 0;
        idle_cycles(1);
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge i_clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d output REs missing at %0t ns", exp_q.size(), $time);
            stop_run();
        end
    endtask

    //----------------------------------------
    // directed tests
    //----------------------------------------
    task automatic reset_behavior();
        apply_reset(RBG_4PRB);
        repeat (3) begin
            @(negedge i_clk);
            check_idle_outputs();
        end
        for (int a = 0; a < `DR_ANT; a++) begin
            stim_i[a] = 100 * a;
            stim_q[a] = -50 * a;
        end
        drive_re(1'b1);
        wait_drain();
        check_val("o_beam_idx[0]", int'(o_beam_idx[0]), 0);
        check_val("o_beam_idx[1]", int'(o_beam_idx[1]), 1);
    endtask

    task automatic beam_signs();
        apply_reset(RBG_16PRB);   // all impulses in the first RBG
        for (int a = 0; a < `DR_ANT; a++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < `DR_ANT; k++) begin
                    stim_i[k] = 0;
                    stim_q[k] = 0;
                end
                stim_i[a] = (s == 0) ? 1000 : -1000;
                stim_q[a] = (s == 0) ? -1000 : 1000;
                drive_re(a == 0 && s == 0);
            end
        end
        wait_drain();
    endtask

    task automatic rbg_segments();
        for (int s = 0; s < 4; s++) begin
            apply_reset(rbg_size_e'(s));
            for (int n = 0; n < 3 * rbg_len + rbg_len / 2 + 1 + rbg_len + 2; n++) begin
                for (int a = 0; a < `DR_ANT; a++) begin
                    stim_i[a] = (n * 37 + a * 101) % 2000 - 1000;
                    stim_q[a] = (n * 53 + a * 29) % 1500 - 750;
                end
                drive_re(n == 0 || n == 3 * rbg_len + rbg_len / 2);   // mid-RBG restart
            end
            wait_drain();
        end
    endtask

    task automatic beam_ranking();
        apply_reset(RBG_4PRB);
        for (int n = 0; n < 14; n++) begin
            for (int a = 0; a < `DR_ANT; a++) begin
                stim_i[a] = 1000 * hadamard_sign(a, 5) + 600 * hadamard_sign(a, 3);
                stim_q[a] = 400 * hadamard_sign(a, 5) - 300 * hadamard_sign(a, 3);
            end
            drive_re(n == 0);
        end
        wait_drain();
        check_val("o_beam_idx[0]", int'(o_beam_idx[0]), 5);
        check_val("o_beam_idx[1]", int'(o_beam_idx[1]), 3);
        // equal energy in beams 6 and 2
        for (int n = 0; n < 14; n++) begin
            for (int a = 0; a < `DR_ANT; a++) begin
                stim_i[a] = 700 * (hadamard_sign(a, 6) + hadamard_sign(a, 2));
                stim_q[a] = 0;
            end
            drive_re(n == 0);
        end
        wait_drain();
        check_val("o_beam_idx[0]", int'(o_beam_idx[0]), 2);
        check_val("o_beam_idx[1]", int'(o_beam_idx[1]), 6);
    endtask

    task automatic random_streams();
        int r;
        bit sop;
        for (int s = 0; s < 4; s++) begin
            apply_reset(rbg_size_e'(s));
            for (int n = 0; n < 150; n++) begin
                r = $random(seed);
                if (r[1:0] == 2'd0)
                    idle_cycles(int'(r[3:2]) + 1);      // gap of 1 to 4 cycles
                sop = (n == 0) || (r[9:4] == 6'd0);
                for (int a = 0; a < `DR_ANT; a++) begin
                    stim_i[a] = int'(iq_t'($random(seed)));
                    stim_q[a] = int'(iq_t'($random(seed)));
                end
                drive_re(sop);
            end
            wait_drain();
        end
    endtask

    initial begin
        #(TOTAL_RE * 10 * 3);
        $display("timeout after %0d ns, the run did not finish", TOTAL_RE * 30);
        stop_run();
    end

    initial begin
        i_reset    = 1'b1;
        i_vld      = 1'b0;
        i_sop      = 1'b0;
        i_rbg_size = RBG_4PRB;
        for (int a = 0; a < `DR_ANT; a++) begin
            i_ant_i[a] = '0;
            i_ant_q[a] = '0;
        end
        seed = 32'h01bb94b4;
        reset_behavior();
        beam_signs();
        rbg_segments();
        beam_ranking();
        random_streams();
        if (exp_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("%0d expected output REs never appeared", exp_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/dr_pkg.sv
hdl/beam_stream_if.sv
hdl/rbg_tracker.sv
hdl/beam_former.sv
hdl/beam_rank.sv
hdl/beam_pick.sv
hdl/dr_core.sv
tb/dr_core_chk.sv
tb/dr_core_tb.sv

// File: Makefile
# Verilator build and run of the dr_core testbench

VERILATOR ?= verilator
TOP       ?= dr_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
